// File: source/ooo_params.svh
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// architectural register count for RV32I
`define OOO_NUM_REGS 32

// data path width
`define OOO_XLEN 32

// number of reorder buffer slots
`define OOO_ROB_DEPTH 8

// rob tag width
// tag 0 means no producer, tag k names slot k-1
`define OOO_TAG_W 4

`endif

// File: source/ooo_pkg.sv
`include "ooo_params.svh"

package ooo_pkg;

    // one data word
    typedef logic [`OOO_XLEN-1:0] word_t;

    // architectural register index
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

    // rob tag, zero is reserved for "no producer"
    typedef logic [`OOO_TAG_W-1:0] tag_t;

    // slot pointer inside the rob
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_ptr_t;

    // lifetime of one rob entry
    typedef enum logic [1:0] {
        rob_empty,
        rob_busy,
        rob_done
    } rob_state_e;

endpackage

// File: source/ooo_if.sv
`timescale 1ns/1ps

// head of the rob retiring into the register file
interface commit_if;
    logic              valid;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::word_t    value;
    ooo_pkg::tag_t     tag;

    modport source (output valid, rd, value, tag);
    modport sink   (input  valid, rd, value, tag);
endinterface

// two combinational read ports on the register file
interface regread_if;
    ooo_pkg::reg_idx_t rs1;
    ooo_pkg::reg_idx_t rs2;
    ooo_pkg::word_t    value1;
    ooo_pkg::word_t    value2;
    ooo_pkg::tag_t     tag1;
    ooo_pkg::tag_t     tag2;

    modport reader (output rs1, rs2, input value1, value2, tag1, tag2);
    modport source (input rs1, rs2, output value1, value2, tag1, tag2);
endinterface

// tag lookup into the rob for finished results
interface rob_lookup_if;
    ooo_pkg::tag_t  qtag1;
    ooo_pkg::tag_t  qtag2;
    logic           hit1;
    logic           hit2;
    ooo_pkg::word_t data1;
    ooo_pkg::word_t data2;

    modport requester (output qtag1, qtag2, input hit1, hit2, data1, data2);
    modport responder (input qtag1, qtag2, output hit1, hit2, data1, data2);
endinterface

// File: source/regfile.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    commit_if.sink            cm,
    regread_if.source         rd_port,
    input  logic              load_tag,
    input  ooo_pkg::reg_idx_t tag_rd,
    input  ooo_pkg::tag_t     tag_new
);

    ooo_pkg::word_t vals [`OOO_NUM_REGS];
    ooo_pkg::tag_t  tags [`OOO_NUM_REGS];

    logic commit_wr;

    // x0 is never written, the read side hardwires it anyway
    assign commit_wr = cm.valid && (cm.rd != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                vals[i] <= '0;
                tags[i] <= '0;
            end
        end else begin
            // a commit in the flush cycle still lands
            if (commit_wr) begin
                vals[cm.rd] <= cm.value;
            end

            if (flush) begin
                for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                    tags[i] <= '0;
                end
            end else begin
                // only drop the tag if no newer producer was renamed on top
                if (commit_wr && (tags[cm.rd] == cm.tag)) begin
                    tags[cm.rd] <= '0;
                end
                // later assignment, so a same-cycle dispatch keeps its new tag
                if (load_tag) begin
                    tags[tag_rd] <= tag_new;
                end
            end
        end
    end

    // read port 1
    always_comb begin
        if (rd_port.rs1 == '0) begin
            rd_port.value1 = '0;
            rd_port.tag1   = '0;
        end else begin
            rd_port.value1 = vals[rd_port.rs1];
            rd_port.tag1   = tags[rd_port.rs1];
        end
    end

    // read port 2
    always_comb begin
        if (rd_port.rs2 == '0) begin
            rd_port.value2 = '0;
            rd_port.tag2   = '0;
        end else begin
            rd_port.value2 = vals[rd_port.rs2];
            rd_port.tag2   = tags[rd_port.rs2];
        end
    end

endmodule

// File: source/rob.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module rob (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              alloc,
    input  ooo_pkg::reg_idx_t alloc_rd,
    output logic              alloc_ready,
    output ooo_pkg::tag_t     alloc_tag,
    input  logic              wb_valid,
    input  ooo_pkg::tag_t     wb_tag,
    input  ooo_pkg::word_t    wb_value,
    commit_if.source          cm,
    rob_lookup_if.responder   lk
);

    ooo_pkg::rob_state_e state [`OOO_ROB_DEPTH];
    ooo_pkg::reg_idx_t   dest  [`OOO_ROB_DEPTH];
    ooo_pkg::word_t      vals  [`OOO_ROB_DEPTH];

    ooo_pkg::rob_ptr_t head;
    ooo_pkg::rob_ptr_t tail;
    ooo_pkg::rob_ptr_t head_nxt;
    logic [$clog2(`OOO_ROB_DEPTH):0] count;

    logic              do_alloc;
    logic              do_commit;
    logic              wb_accept;
    ooo_pkg::rob_ptr_t wb_slot;

    // tag k lives in slot k-1
    function automatic ooo_pkg::rob_ptr_t tag_slot(input ooo_pkg::tag_t t);
        ooo_pkg::tag_t idx;
        idx = t - ooo_pkg::tag_t'(1);
        return ooo_pkg::rob_ptr_t'(idx);
    endfunction

    function automatic logic tag_valid(input ooo_pkg::tag_t t);
        return (t != '0) && (t <= ooo_pkg::tag_t'(`OOO_ROB_DEPTH));
    endfunction

    assign alloc_ready = (count != `OOO_ROB_DEPTH);
    assign alloc_tag   = ooo_pkg::tag_t'(tail) + ooo_pkg::tag_t'(1);
    assign do_alloc    = alloc && alloc_ready && !flush;

    // an empty slot is never done, so this also covers count == 0
    assign do_commit = (state[head] == ooo_pkg::rob_done);
    assign head_nxt  = do_commit ? head + 1'b1 : head;

    assign wb_slot   = tag_slot(wb_tag);
    assign wb_accept = wb_valid && tag_valid(wb_tag) && (state[wb_slot] == ooo_pkg::rob_busy);

    // head entry drives the commit bus directly
    assign cm.valid = do_commit;
    assign cm.rd    = dest[head];
    assign cm.value = vals[head];
    assign cm.tag   = ooo_pkg::tag_t'(head) + ooo_pkg::tag_t'(1);

    // only finished results count as hits
    assign lk.hit1  = tag_valid(lk.qtag1) && (state[tag_slot(lk.qtag1)] == ooo_pkg::rob_done);
    assign lk.hit2  = tag_valid(lk.qtag2) && (state[tag_slot(lk.qtag2)] == ooo_pkg::rob_done);
    assign lk.data1 = vals[tag_slot(lk.qtag1)];
    assign lk.data2 = vals[tag_slot(lk.qtag2)];

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                state[i] <= ooo_pkg::rob_empty;
            end
        end else if (flush) begin
            // restart right behind whatever retires this cycle
            head  <= head_nxt;
            tail  <= head_nxt;
            count <= '0;
            for (int i = 0; i < `OOO_ROB_DEPTH; i++) begin
                state[i] <= ooo_pkg::rob_empty;
            end
        end else begin
            if (do_commit) begin
                state[head] <= ooo_pkg::rob_empty;
            end
            if (wb_accept) begin
                state[wb_slot] <= ooo_pkg::rob_done;
            end
            if (do_alloc) begin
                state[tail] <= ooo_pkg::rob_busy;
                tail        <= tail + 1'b1;
            end
            head <= head_nxt;
            if (do_alloc && !do_commit) begin
                count <= count + 1'b1;
            end else if (!do_alloc && do_commit) begin
                count <= count - 1'b1;
            end
        end
    end

    // payload, qualified by state above
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            dest[tail] <= alloc_rd;
        end
        if (wb_accept) begin
            vals[wb_slot] <= wb_value;
        end
    end

endmodule

// File: source/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve (
    input  ooo_pkg::reg_idx_t disp_rs1,
    input  ooo_pkg::reg_idx_t disp_rs2,
    regread_if.reader         rd_port,
    rob_lookup_if.requester   lk,
    output ooo_pkg::word_t    op1_value,
    output ooo_pkg::word_t    op2_value,
    output ooo_pkg::tag_t     op1_tag,
    output ooo_pkg::tag_t     op2_tag
);

    // committed value, finished rob value, or zero while waiting
    function automatic ooo_pkg::word_t pick_value(
        input ooo_pkg::tag_t  rf_tag,
        input ooo_pkg::word_t rf_value,
        input logic           rob_hit,
        input ooo_pkg::word_t rob_data
    );
        if (rf_tag == '0) begin
            return rf_value;
        end else if (rob_hit) begin
            return rob_data;
        end
        return '0;
    endfunction

    // tag survives only if the producer has not finished yet
    function automatic ooo_pkg::tag_t pick_tag(
        input ooo_pkg::tag_t rf_tag,
        input logic          rob_hit
    );
        return rob_hit ? '0 : rf_tag;
    endfunction

    assign rd_port.rs1 = disp_rs1;
    assign rd_port.rs2 = disp_rs2;

    // ask the rob about whoever the regfile says is pending
    assign lk.qtag1 = rd_port.tag1;
    assign lk.qtag2 = rd_port.tag2;

    assign op1_value = pick_value(rd_port.tag1, rd_port.value1, lk.hit1, lk.data1);
    assign op2_value = pick_value(rd_port.tag2, rd_port.value2, lk.hit2, lk.data2);
    assign op1_tag   = pick_tag(rd_port.tag1, lk.hit1);
    assign op2_tag   = pick_tag(rd_port.tag2, lk.hit2);

endmodule

// File: source/rename_core.sv
`timescale 1ns/1ps

module rename_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,

    // dispatch
    input  logic              disp_valid,
    input  ooo_pkg::reg_idx_t disp_rd,
    input  ooo_pkg::reg_idx_t disp_rs1,
    input  ooo_pkg::reg_idx_t disp_rs2,
    output logic              disp_ready,
    output ooo_pkg::tag_t     disp_tag,

    // writeback
    input  logic              wb_valid,
    input  ooo_pkg::tag_t     wb_tag,
    input  ooo_pkg::word_t    wb_value,

    // resolved operands
    output ooo_pkg::word_t    op1_value,
    output ooo_pkg::word_t    op2_value,
    output ooo_pkg::tag_t     op1_tag,
    output ooo_pkg::tag_t     op2_tag,

    // commit
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::word_t    commit_value
);

    commit_if     cm_bus ();
    regread_if    rr_bus ();
    rob_lookup_if lk_bus ();

    logic disp_accept;
    logic load_tag;

    assign disp_accept = disp_valid && disp_ready;
    // x0 gets a rob slot but never a pending tag
    assign load_tag = disp_accept && (disp_rd != '0);

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .cm       (cm_bus.sink),
        .rd_port  (rr_bus.source),
        .load_tag (load_tag),
        .tag_rd   (disp_rd),
        .tag_new  (disp_tag)
    );

    rob u_rob (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc       (disp_accept),
        .alloc_rd    (disp_rd),
        .alloc_ready (disp_ready),
        .alloc_tag   (disp_tag),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .wb_value    (wb_value),
        .cm          (cm_bus.source),
        .lk          (lk_bus.responder)
    );

    operand_resolve u_resolve (
        .disp_rs1  (disp_rs1),
        .disp_rs2  (disp_rs2),
        .rd_port   (rr_bus.reader),
        .lk        (lk_bus.requester),
        .op1_value (op1_value),
        .op2_value (op2_value),
        .op1_tag   (op1_tag),
        .op2_tag   (op2_tag)
    );

    assign commit_valid = cm_bus.valid;
    assign commit_rd    = cm_bus.rd;
    assign commit_value = cm_bus.value;

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns  = 100,
    parameter int rst_cycles = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

    // release just after the edge, like every other tb input
    initial begin
        rst = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: dv/rename_core_chk.sv
`timescale 1ns/1ps
`include "ooo_params.svh"

module rename_core_chk (
    input logic                            clk,
    input logic                            rst,
    input logic                            alloc_ready,
    input logic [$clog2(`OOO_ROB_DEPTH):0] count,
    input logic                            do_commit,
    input ooo_pkg::rob_ptr_t               head,
    input ooo_pkg::rob_state_e             tail_state,
    input logic                            wb_accept,
    input ooo_pkg::rob_ptr_t               wb_slot
);

    // a full rob must stall dispatch
    // an occupied tail slot means every slot is in use
    full_stalls_dispatch: assert property (@(posedge clk) disable iff (rst)
        (tail_state != ooo_pkg::rob_empty) |-> !alloc_ready)
        else $error("dispatch ready while every rob slot is occupied");

    // retire only from a live head entry
    commit_needs_entry: assert property (@(posedge clk) disable iff (rst)
        do_commit |-> (count != '0))
        else $error("commit while the rob holds no entries");

    // results only land between head and tail
    wb_needs_entry: assert property (@(posedge clk) disable iff (rst)
        wb_accept |-> (ooo_pkg::rob_ptr_t'(wb_slot - head) < count))
        else $error("writeback accepted outside the occupied rob window");

endmodule

// File: dv/rename_core_tb.sv
`timescale 1ns/1ps

module rename_core_tb;

    typedef enum logic [1:0] {k_idle, k_dispatch, k_writeback, k_flush} kind_e;

    // one table row: stimulus, then the outputs expected before the next edge
    typedef struct packed {
        kind_e             kind;
        ooo_pkg::reg_idx_t rd;
        ooo_pkg::reg_idx_t rs1;
        ooo_pkg::reg_idx_t rs2;
        ooo_pkg::tag_t     wtag;
        ooo_pkg::word_t    wval;
        ooo_pkg::word_t    e_op1;
        ooo_pkg::tag_t     e_tag1;
        ooo_pkg::word_t    e_op2;
        ooo_pkg::tag_t     e_tag2;
        logic              e_ready;
        ooo_pkg::tag_t     e_dtag;
        logic              e_cv;
        ooo_pkg::reg_idx_t e_crd;
        ooo_pkg::word_t    e_cval;
    } row_t;

    // writeback payloads
    localparam int wb1 = 32'h1111_0001;
    localparam int wb2 = 32'h2222_0002;
    localparam int wb3 = 32'h3333_0003;
    localparam int wb5 = 32'h5555_0005;
    localparam int wb6 = 32'h6666_0006;
    localparam int wbd = 32'hdead_0000;

    logic              clk;
    logic              rst;
    logic              flush;
    logic              disp_valid;
    ooo_pkg::reg_idx_t disp_rd;
    ooo_pkg::reg_idx_t disp_rs1;
    ooo_pkg::reg_idx_t disp_rs2;
    logic              disp_ready;
    ooo_pkg::tag_t     disp_tag;
    logic              wb_valid;
    ooo_pkg::tag_t     wb_tag;
    ooo_pkg::word_t    wb_value;
    ooo_pkg::word_t    op1_value;
    ooo_pkg::word_t    op2_value;
    ooo_pkg::tag_t     op1_tag;
    ooo_pkg::tag_t     op2_tag;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::word_t    commit_value;

    row_t   rows[$];
    integer seed;
    int     row_idx;
    bit     row_ok;
    int     pass_count;
    int     fail_count;
    int     cycles;
    int     limit;

    tb_clk_gen #(.period_ns(100), .rst_cycles(5)) u_clk_gen (.clk(clk), .rst(rst));

    rename_core u_dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .disp_valid   (disp_valid),
        .disp_rd      (disp_rd),
        .disp_rs1     (disp_rs1),
        .disp_rs2     (disp_rs2),
        .disp_ready   (disp_ready),
        .disp_tag     (disp_tag),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag),
        .wb_value     (wb_value),
        .op1_value    (op1_value),
        .op2_value    (op2_value),
        .op1_tag      (op1_tag),
        .op2_tag      (op2_tag),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    bind rob rename_core_chk u_chk (
        .clk         (clk),
        .rst         (rst),
        .alloc_ready (alloc_ready),
        .count       (count),
        .do_commit   (do_commit),
        .head        (head),
        .tail_state  (state[tail]),
        .wb_accept   (wb_accept),
        .wb_slot     (wb_slot)
    );

    task automatic add_row(input kind_e kind, input int rd, input int rs1, input int rs2,
                           input int wtag, input int wval, input int op1, input int tag1,
                           input int op2, input int tag2, input int rdy, input int dtag,
                           input int cv, input int crd, input int cval);
        row_t r;
        r.kind    = kind;
        r.rd      = ooo_pkg::reg_idx_t'(rd);
        r.rs1     = ooo_pkg::reg_idx_t'(rs1);
        r.rs2     = ooo_pkg::reg_idx_t'(rs2);
        r.wtag    = ooo_pkg::tag_t'(wtag);
        r.wval    = ooo_pkg::word_t'(wval);
        r.e_op1   = ooo_pkg::word_t'(op1);
        r.e_tag1  = ooo_pkg::tag_t'(tag1);
        r.e_op2   = ooo_pkg::word_t'(op2);
        r.e_tag2  = ooo_pkg::tag_t'(tag2);
        r.e_ready = (rdy != 0);
        r.e_dtag  = ooo_pkg::tag_t'(dtag);
        r.e_cv    = (cv != 0);
        r.e_crd   = ooo_pkg::reg_idx_t'(crd);
        r.e_cval  = ooo_pkg::word_t'(cval);
        rows.push_back(r);
    endtask

    task automatic build_table();
        kind_e rk;
        int    rtag;
        // after reset every register reads zero with no producer
        for (int i = 0; i < 16; i++) begin
            add_row(k_idle, 0, i, 31 - i, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0);
        end
        // three producers for x3, newest tag wins
        add_row(k_dispatch,  3, 3, 0, 0, 0,   0,   0, 0,   0, 1, 1, 0, 0, 0);
        add_row(k_dispatch,  3, 3, 3, 0, 0,   0,   1, 0,   1, 1, 2, 0, 0, 0);
        add_row(k_dispatch,  3, 3, 4, 0, 0,   0,   2, 0,   0, 1, 3, 0, 0, 0);
        add_row(k_idle,      0, 3, 3, 0, 0,   0,   3, 0,   3, 1, 4, 0, 0, 0);
        // out of order results, in order commits, tag 3 stays on x3
        add_row(k_writeback, 0, 3, 0, 2, wb2, 0,   3, 0,   0, 1, 4, 0, 0, 0);
        add_row(k_idle,      0, 3, 0, 0, 0,   0,   3, 0,   0, 1, 4, 0, 0, 0);
        add_row(k_writeback, 0, 3, 0, 1, wb1, 0,   3, 0,   0, 1, 4, 0, 0, 0);
        add_row(k_idle,      0, 3, 0, 0, 0,   0,   3, 0,   0, 1, 4, 1, 3, wb1);
        add_row(k_idle,      0, 3, 0, 0, 0,   0,   3, 0,   0, 1, 4, 1, 3, wb2);
        add_row(k_writeback, 0, 3, 3, 3, wb3, 0,   3, 0,   3, 1, 4, 0, 0, 0);
        add_row(k_idle,      0, 3, 3, 0, 0,   wb3, 0, wb3, 0, 1, 4, 1, 3, wb3);
        add_row(k_idle,      0, 3, 3, 0, 0,   wb3, 0, wb3, 0, 1, 4, 0, 0, 0);
        // fill all eight slots, tags wrap after 8
        for (int i = 0; i < 8; i++) begin
            add_row(k_dispatch, 5 + i, 3, 0, 0, 0, wb3, 0, 0, 0, 1, ((3 + i) % 8) + 1, 0, 0, 0);
        end
        // ninth dispatch is held until the head retires
        add_row(k_dispatch, 13, 5, 12, 0, 0,   0,   4, 0,   3, 0, 4, 0, 0, 0);
        add_row(k_writeback, 0, 5,  0, 4, wb5, 0,   4, 0,   0, 0, 4, 0, 0, 0);
        add_row(k_dispatch, 13, 5, 12, 0, 0,   wb5, 0, 0,   3, 0, 4, 1, 5, wb5);
        add_row(k_dispatch, 13, 5, 13, 0, 0,   wb5, 0, 0,   0, 1, 4, 0, 0, 0);
        add_row(k_idle,      0, 13, 12, 0, 0,  0,   4, 0,   3, 0, 5, 0, 0, 0);
        // flush while the head commits
        add_row(k_writeback, 0, 6,  0, 5, wb6, 0,   5, 0,   0, 0, 5, 0, 0, 0);
        add_row(k_flush,     0, 6,  7, 0, 0,   wb6, 0, 0,   6, 0, 5, 1, 6, wb6);
        add_row(k_idle,      0, 6, 13, 0, 0,   wb6, 0, 0,   0, 1, 6, 0, 0, 0);
        add_row(k_idle,      0, 12, 5, 0, 0,   0,   0, wb5, 0, 1, 6, 0, 0, 0);
        // x0 takes a slot but never a tag
        add_row(k_dispatch,  0, 0, 6, 0, 0,   0,   0, wb6, 0, 1, 6, 0, 0, 0);
        add_row(k_idle,      0, 0, 0, 0, 0,   0,   0, 0,   0, 1, 7, 0, 0, 0);
        add_row(k_writeback, 0, 0, 6, 6, wbd, 0,   0, wb6, 0, 1, 7, 0, 0, 0);
        add_row(k_idle,      0, 0, 6, 0, 0,   0,   0, wb6, 0, 1, 7, 1, 0, wbd);
        add_row(k_idle,      0, 0, 6, 0, 0,   0,   0, wb6, 0, 1, 7, 0, 0, 0);
        // stray writebacks into an empty rob change nothing
        seed = 32'hcf5d_b98e;
        for (int i = 0; i < 8; i++) begin
            rk   = (($random(seed) & 1) != 0) ? k_writeback : k_idle;
            rtag = ($random(seed) & 7) + 1;
            add_row(rk, 0, 6, 5, rtag, $random(seed), wb6, 0, wb5, 0, 1, 7, 0, 0, 0);
        end
    endtask

    task automatic drive_row(input row_t r);
        disp_valid = (r.kind == k_dispatch);
        disp_rd    = r.rd;
        disp_rs1   = r.rs1;
        disp_rs2   = r.rs2;
        wb_valid   = (r.kind == k_writeback);
        wb_tag     = r.wtag;
        wb_value   = r.wval;
        flush      = (r.kind == k_flush);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: row %0d %s got %h expected %h",
                     $time, row_idx, name, got, exp);
            row_ok = 1'b0;
        end
    endtask

    task automatic check_row(input row_t r);
        compare_field("op1_value", op1_value, r.e_op1);
        compare_field("op1_tag", 32'(op1_tag), 32'(r.e_tag1));
        compare_field("op2_value", op2_value, r.e_op2);
        compare_field("op2_tag", 32'(op2_tag), 32'(r.e_tag2));
        compare_field("disp_ready", 32'(disp_ready), 32'(r.e_ready));
        compare_field("disp_tag", 32'(disp_tag), 32'(r.e_dtag));
        compare_field("commit_valid", 32'(commit_valid), 32'(r.e_cv));
        // rd and value on the commit bus only mean something while valid
        if (r.e_cv) begin
            compare_field("commit_rd", 32'(commit_rd), 32'(r.e_crd));
            compare_field("commit_value", commit_value, r.e_cval);
        end
    endtask

    function automatic string kind_name(input kind_e k);
        case (k)
            k_dispatch:  return "dispatch";
            k_writeback: return "writeback";
            k_flush:     return "flush";
            default:     return "idle";
        endcase
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        flush      = 1'b0;
        disp_valid = 1'b0;
        disp_rd    = '0;
        disp_rs1   = '0;
        disp_rs2   = '0;
        wb_valid   = 1'b0;
        wb_tag     = '0;
        wb_value   = '0;
        pass_count = 0;
        fail_count = 0;
        cycles     = 0;
        build_table();
        limit = rows.size() + 20;
        @(negedge rst);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            drive_row(rows[i]);
            #60;
            row_idx = i;
            row_ok  = 1'b1;
            check_row(rows[i]);
            if (row_ok) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("row %0d %s %s", i, kind_name(rows[i].kind), row_ok ? "ok" : "mismatch");
        end
        $display("rows passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+source
source/ooo_pkg.sv
source/ooo_if.sv
source/regfile.sv
source/rob.sv
source/operand_resolve.sv
source/rename_core.sv
dv/tb_clk_gen.sv
dv/rename_core_chk.sv
dv/rename_core_tb.sv

// File: Makefile
# Verilator simulation of the rename core testbench

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: run clean

# build, run, and pass only if the testbench printed its pass line
run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)
